// ==== cache_macros.svh ====
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// cache geometry, all sizes as log2 except the way count

// words per line
`define LINE_ADDR_LEN 3

// number of sets
`define SET_ADDR_LEN 3

// tag bits kept per line
`define TAG_ADDR_LEN 10

// ways per set
`define WAY_CNT 4

// data word width and byte offset bits
`define WORD_W 32
`define BYTE_ADDR_LEN 2

`endif

// ==== cache_pkg.sv ====
`include "cache_macros.svh"

package cache_pkg;

    // address bits above the tag, not used by the cache
    localparam int UNUSED_ADDR_LEN =
        32 - `TAG_ADDR_LEN - `SET_ADDR_LEN - `LINE_ADDR_LEN - `BYTE_ADDR_LEN;

    // cpu byte address split into cache fields, msb first
    typedef struct packed {
        logic [UNUSED_ADDR_LEN-1:0] unused;
        logic [`TAG_ADDR_LEN-1:0]   tag;
        logic [`SET_ADDR_LEN-1:0]   set_idx;
        logic [`LINE_ADDR_LEN-1:0]  word;
        logic [`BYTE_ADDR_LEN-1:0]  offset;
    } cache_addr_t;

    // store width
    typedef enum logic [1:0] {
        ST_BYTE,
        ST_HALF,
        ST_WORD
    } store_kind_e;

    // request levels, held by the cpu until finish
    typedef struct packed {
        logic                rd;
        logic                wr;
        store_kind_e         kind;
        logic [31:0]         addr;
        logic [`WORD_W-1:0]  wdata;
    } cpu_req_t;

    typedef struct packed {
        logic               finish;
        logic               miss;
        logic [`WORD_W-1:0] rdata;
    } cpu_rsp_t;

    // controller states
    typedef enum logic [1:0] {
        ST_READY,
        ST_WRITEBACK,
        ST_REFILL
    } ctrl_state_e;

    typedef logic [$clog2(`WAY_CNT)-1:0] way_idx_t;

endpackage

// ==== mem_bus_pkg.sv ====
`include "cache_macros.svh"

package mem_bus_pkg;

    // whole cache line, word 0 sits in the top bits
    typedef logic [0:(1 << `LINE_ADDR_LEN)-1][`WORD_W-1:0] line_t;

    // rd and wr are levels, held until done
    typedef struct packed {
        logic        rd;
        logic        wr;
        // line aligned byte address
        logic [31:0] addr;
        line_t       wdata;
    } mem_req_t;

    // done pulses for one cycle, rdata valid with it
    typedef struct packed {
        logic  done;
        line_t rdata;
    } mem_rsp_t;

endpackage

// ==== cache_ctrl_fsm.sv ====
`timescale 1ns/1ps

module cache_ctrl_fsm
    import cache_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  cpu_req_t    cpu_req_i,
    input  logic        hit_i,
    input  logic        victim_dirty_i,
    input  logic [31:0] wb_addr_i,
    input  line_t       wb_line_i,
    input  mem_rsp_t    mem_rsp_i,
    output logic        store_en_o,
    output logic        fill_en_o,
    output logic        advance_o,
    output logic        cpu_finish_o,
    output mem_req_t    mem_req_o
);

    ctrl_state_e state_q;
    logic        finish_q;
    logic        req_present;
    logic        hit_ready;
    cache_addr_t fill_addr;

    assign req_present = cpu_req_i.rd || cpu_req_i.wr;

    // pending request that hits, finish not yet given
    assign hit_ready = (state_q == ST_READY) && req_present && !finish_q && hit_i;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q  <= ST_READY;
            finish_q <= 1'b0;
        end
        else
        begin
            // one cycle pulse, drops even if the request is still held
            finish_q <= hit_ready;
            case (state_q)
                ST_READY:
                begin
                    // miss: dirty victim goes out before the refill
                    if (req_present && !finish_q && !hit_i)
                    begin
                        if (victim_dirty_i)
                        begin
                            state_q <= ST_WRITEBACK;
                        end
                        else
                        begin
                            state_q <= ST_REFILL;
                        end
                    end
                end
                ST_WRITEBACK:
                begin
                    if (mem_rsp_i.done)
                    begin
                        state_q <= ST_REFILL;
                    end
                end
                ST_REFILL:
                begin
                    // line lands this cycle, request hits afterwards
                    if (mem_rsp_i.done)
                    begin
                        state_q <= ST_READY;
                    end
                end
                default:
                begin
                    state_q <= ST_READY;
                end
            endcase
        end
    end

    assign store_en_o   = hit_ready && cpu_req_i.wr;
    assign fill_en_o    = (state_q == ST_REFILL) && mem_rsp_i.done;
    // round robin steps once per refill
    assign advance_o    = fill_en_o;
    assign cpu_finish_o = finish_q;

    always_comb
    begin
        // refill address is the request with line bits cleared
        fill_addr        = cpu_req_i.addr;
        fill_addr.word   = '0;
        fill_addr.offset = '0;
        mem_req_o.rd     = (state_q == ST_REFILL);
        mem_req_o.wr     = (state_q == ST_WRITEBACK);
        mem_req_o.wdata  = wb_line_i;
        if (state_q == ST_REFILL)
        begin
            mem_req_o.addr = fill_addr;
        end
        else if (state_q == ST_WRITEBACK)
        begin
            mem_req_o.addr = wb_addr_i;
        end
        else
        begin
            mem_req_o.addr = '0;
        end
    end

    // memory never sees read and write at once
    a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
        !(mem_req_o.rd && mem_req_o.wr));

endmodule

// ==== replace_ctr.sv ====
`timescale 1ns/1ps

`include "cache_macros.svh"

module replace_ctr
    import cache_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`SET_ADDR_LEN-1:0] set_i,
    input  logic                     advance_i,
    output way_idx_t                 victim_way_o
);

    localparam int SET_CNT = 1 << `SET_ADDR_LEN;

    // next way to replace, one per set
    way_idx_t ctr_q [SET_CNT];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < SET_CNT; s++)
            begin
                ctr_q[s] <= '0;
            end
        end
        else if (advance_i)
        begin
            // wrap explicitly, way count need not be a power of two
            if (ctr_q[set_i] == way_idx_t'(`WAY_CNT - 1))
            begin
                ctr_q[set_i] <= '0;
            end
            else
            begin
                ctr_q[set_i] <= ctr_q[set_i] + 1'b1;
            end
        end
    end

    // ways fill in order, so fifo equals round robin
    assign victim_way_o = ctr_q[set_i];

endmodule

// ==== tag_store.sv ====
`timescale 1ns/1ps

`include "cache_macros.svh"

module tag_store
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  cache_addr_t addr_i,
    input  way_idx_t    victim_way_i,
    input  logic        store_en_i,
    input  logic        fill_en_i,
    output logic        hit_o,
    output way_idx_t    hit_way_o,
    output logic        victim_dirty_o,
    output logic [31:0] wb_addr_o
);

    localparam int SET_CNT = 1 << `SET_ADDR_LEN;

    logic [`TAG_ADDR_LEN-1:0] tag_q [SET_CNT][`WAY_CNT];
    logic [`WAY_CNT-1:0]      valid_q [SET_CNT];
    logic [`WAY_CNT-1:0]      dirty_q [SET_CNT];
    logic [`WAY_CNT-1:0]      hit_vec;
    cache_addr_t              wb_addr;

    // tag compare on every valid way of the set
    always_comb
    begin
        for (int w = 0; w < `WAY_CNT; w++)
        begin
            hit_vec[w] = valid_q[addr_i.set_idx][w]
                && (tag_q[addr_i.set_idx][w] == addr_i.tag);
        end
    end

    assign hit_o = |hit_vec;

    // encode hit way
    always_comb
    begin
        hit_way_o = '0;
        for (int w = 0; w < `WAY_CNT; w++)
        begin
            if (hit_vec[w])
            begin
                hit_way_o = way_idx_t'(w);
            end
        end
    end

    // victim needs write-back only if valid and dirty
    assign victim_dirty_o = valid_q[addr_i.set_idx][victim_way_i]
        && dirty_q[addr_i.set_idx][victim_way_i];

    // victim line address from its tag and the current set
    always_comb
    begin
        wb_addr         = '0;
        wb_addr.tag     = tag_q[addr_i.set_idx][victim_way_i];
        wb_addr.set_idx = addr_i.set_idx;
    end

    assign wb_addr_o = wb_addr;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int s = 0; s < SET_CNT; s++)
            begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end
        else if (fill_en_i)
        begin
            // fresh line from memory is clean
            valid_q[addr_i.set_idx][victim_way_i] <= 1'b1;
            dirty_q[addr_i.set_idx][victim_way_i] <= 1'b0;
        end
        else if (store_en_i)
        begin
            dirty_q[addr_i.set_idx][hit_way_o] <= 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (fill_en_i)
        begin
            tag_q[addr_i.set_idx][victim_way_i] <= addr_i.tag;
        end
    end

    // fills only happen on a miss, so tags never duplicate in a set
    a_hit_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(hit_vec));

    // held request hits right after its refill
    a_fill_then_hit: assert property (@(posedge clk) disable iff (rst)
        fill_en_i |=> hit_o);

endmodule

// ==== data_store.sv ====
`timescale 1ns/1ps

`include "cache_macros.svh"

module data_store
    import cache_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  cache_addr_t        addr_i,
    input  cpu_req_t           cpu_req_i,
    input  way_idx_t           hit_way_i,
    input  way_idx_t           victim_way_i,
    input  logic               store_en_i,
    input  logic               fill_en_i,
    input  line_t              fill_line_i,
    output logic [`WORD_W-1:0] rdata_o,
    output line_t              victim_line_o
);

    localparam int SET_CNT = 1 << `SET_ADDR_LEN;

    line_t              data_q [SET_CNT][`WAY_CNT];
    logic [`WORD_W-1:0] hit_word;
    logic [`WORD_W-1:0] merged_word;

    // addressed word of the hit way
    assign hit_word = data_q[addr_i.set_idx][hit_way_i][addr_i.word];

    // store merge, byte 0 is the most significant byte
    always_comb
    begin
        merged_word = hit_word;
        case (cpu_req_i.kind)
            ST_BYTE:
            begin
                merged_word[8 * (3 - int'(addr_i.offset)) +: 8] = cpu_req_i.wdata[7:0];
            end
            ST_HALF:
            begin
                // offset 0 upper half, offset 2 lower half
                merged_word[16 * (1 - int'(addr_i.offset[1])) +: 16] =
                    cpu_req_i.wdata[15:0];
            end
            default:
            begin
                merged_word = cpu_req_i.wdata;
            end
        endcase
    end

    // fill and store never coincide, fill is refill state only
    always_ff @(posedge clk)
    begin
        if (fill_en_i)
        begin
            data_q[addr_i.set_idx][victim_way_i] <= fill_line_i;
        end
        else if (store_en_i)
        begin
            data_q[addr_i.set_idx][hit_way_i][addr_i.word] <= merged_word;
        end
    end

    // sampled each read cycle, valid when finish is up
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            rdata_o <= '0;
        end
        else if (cpu_req_i.rd)
        begin
            rdata_o <= hit_word;
        end
    end

    // whole victim line for the write-back
    assign victim_line_o = data_q[addr_i.set_idx][victim_way_i];

    // cpu must align halfword stores
    a_half_aligned: assert property (@(posedge clk) disable iff (rst)
        (store_en_i && cpu_req_i.kind == ST_HALF) |-> !addr_i.offset[0]);

endmodule

// ==== data_cache.sv ====
`timescale 1ns/1ps

`include "cache_macros.svh"

module data_cache
    import cache_pkg::*;
    import mem_bus_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  cpu_req_t cpu_req_i,
    output cpu_rsp_t cpu_rsp_o,
    input  mem_rsp_t mem_rsp_i,
    output mem_req_t mem_req_o
);

    cache_addr_t        req_addr;
    logic               hit;
    way_idx_t           hit_way;
    way_idx_t           victim_way;
    logic               victim_dirty;
    logic [31:0]        wb_addr;
    line_t              victim_line;
    logic               store_en;
    logic               fill_en;
    logic               advance;
    logic               cpu_finish;
    logic [`WORD_W-1:0] rdata;

    // field view of the request address
    assign req_addr = cpu_req_i.addr;

    // miss stays up while a request waits for finish
    assign cpu_rsp_o = '{
        finish: cpu_finish,
        miss:   (cpu_req_i.rd || cpu_req_i.wr) && !cpu_finish,
        rdata:  rdata
    };

    cache_ctrl_fsm u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .cpu_req_i      (cpu_req_i),
        .hit_i          (hit),
        .victim_dirty_i (victim_dirty),
        .wb_addr_i      (wb_addr),
        .wb_line_i      (victim_line),
        .mem_rsp_i      (mem_rsp_i),
        .store_en_o     (store_en),
        .fill_en_o      (fill_en),
        .advance_o      (advance),
        .cpu_finish_o   (cpu_finish),
        .mem_req_o      (mem_req_o)
    );

    replace_ctr u_repl (
        .clk          (clk),
        .rst          (rst),
        .set_i        (req_addr.set_idx),
        .advance_i    (advance),
        .victim_way_o (victim_way)
    );

    tag_store u_tags (
        .clk            (clk),
        .rst            (rst),
        .addr_i         (req_addr),
        .victim_way_i   (victim_way),
        .store_en_i     (store_en),
        .fill_en_i      (fill_en),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .victim_dirty_o (victim_dirty),
        .wb_addr_o      (wb_addr)
    );

    // refill line comes straight off the memory response
    data_store u_data (
        .clk           (clk),
        .rst           (rst),
        .addr_i        (req_addr),
        .cpu_req_i     (cpu_req_i),
        .hit_way_i     (hit_way),
        .victim_way_i  (victim_way),
        .store_en_i    (store_en),
        .fill_en_i     (fill_en),
        .fill_line_i   (mem_rsp_i.rdata),
        .rdata_o       (rdata),
        .victim_line_o (victim_line)
    );

endmodule

// ==== tb_mem_model.sv ====
`timescale 1ns/1ps

`include "cache_macros.svh"

module tb_mem_model
    import mem_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  mem_req_t    mem_req_i,
    output mem_rsp_t    mem_rsp_o,
    output int          wb_cnt_o,
    output logic [31:0] wb_addr_o,
    output line_t       wb_line_o
);

    localparam int LINE_WORDS = 1 << `LINE_ADDR_LEN;

    // word addressed, filled on first touch
    logic [31:0] mem [logic [31:0]];

    logic        seeded = 1'b0;
    logic [1:0]  wait_cnt;
    logic        done_q;
    line_t       rdata_q;
    line_t       rd_line;
    logic [31:0] base_waddr;

    assign base_waddr = {2'b00, mem_req_i.addr[31:2]};
    assign mem_rsp_o  = '{done: done_q, rdata: rdata_q};

    // untouched words get a random value once
    function automatic logic [31:0] word_at(logic [31:0] waddr);
        if (!mem.exists(waddr))
        begin
            mem[waddr] = $urandom;
        end
        return mem[waddr];
    endfunction

    always @(posedge clk)
    begin
        if (rst)
        begin
            if (!seeded)
            begin
                void'($urandom(32'h9fb9_18f8));
                seeded = 1'b1;
            end
            done_q    <= 1'b0;
            wait_cnt  <= '0;
            rdata_q   <= '0;
            wb_cnt_o  <= 0;
            wb_addr_o <= '0;
            wb_line_o <= '0;
        end
        else if (done_q)
        begin
            // request drops or switches at this edge
            done_q   <= 1'b0;
            wait_cnt <= '0;
        end
        else if (mem_req_i.rd || mem_req_i.wr)
        begin
            // third cycle of the request
            if (wait_cnt == 2'd2)
            begin
                done_q   <= 1'b1;
                wait_cnt <= '0;
                if (mem_req_i.wr)
                begin
                    for (int i = 0; i < LINE_WORDS; i++)
                    begin
                        mem[base_waddr + 32'(i)] = mem_req_i.wdata[i];
                    end
                    wb_cnt_o  <= wb_cnt_o + 1;
                    wb_addr_o <= mem_req_i.addr;
                    wb_line_o <= mem_req_i.wdata;
                end
                else
                begin
                    for (int i = 0; i < LINE_WORDS; i++)
                    begin
                        rd_line[i] = word_at(base_waddr + 32'(i));
                    end
                    rdata_q <= rd_line;
                end
            end
            else
            begin
                wait_cnt <= wait_cnt + 2'd1;
            end
        end
    end

endmodule

// ==== tb_data_cache.sv ====
`timescale 1ns/1ps

`include "cache_macros.svh"

module tb_data_cache
    import cache_pkg::*;
    import mem_bus_pkg::*;
();

    typedef logic [`TAG_ADDR_LEN-1:0] tag_t;

    // about 40 accesses, worst about 20 cycles each, 5x margin
    localparam int ACCESS_BUDGET     = 40;
    localparam int CYCLES_PER_ACCESS = 20;
    localparam int MAX_CYCLES        = ACCESS_BUDGET * CYCLES_PER_ACCESS * 5;

    localparam logic [`SET_ADDR_LEN-1:0]  TEST_SET   = `SET_ADDR_LEN'(2);
    localparam logic [`LINE_ADDR_LEN-1:0] STORE_WORD = `LINE_ADDR_LEN'(3);

    logic        clk;
    logic        rst;
    cpu_req_t    cpu_req;
    cpu_rsp_t    cpu_rsp;
    mem_req_t    mem_req;
    mem_rsp_t    mem_rsp;
    int          wb_cnt;
    logic [31:0] wb_addr;
    line_t       wb_line;

    // bus monitor results
    int          cycle_cnt   = 0;
    int          rd_cnt      = 0;
    int          wr_cnt      = 0;
    int          bus_err_cnt = 0;
    logic [31:0] fill_addr   = '0;
    line_t       fill_line   = '0;

    int          err_cnt       = 0;
    int          test_cnt      = 0;
    int          test_fail_cnt = 0;
    // tb copy of the first line, tag 1
    line_t              first_line;
    logic [`WORD_W-1:0] first_val;
    logic [`WORD_W-1:0] stored_word;

    data_cache UUT (
        .clk       (clk),
        .rst       (rst),
        .cpu_req_i (cpu_req),
        .cpu_rsp_o (cpu_rsp),
        .mem_rsp_i (mem_rsp),
        .mem_req_o (mem_req)
    );

    tb_mem_model mem_model (
        .clk       (clk),
        .rst       (rst),
        .mem_req_i (mem_req),
        .mem_rsp_o (mem_rsp),
        .wb_cnt_o  (wb_cnt),
        .wb_addr_o (wb_addr),
        .wb_line_o (wb_line)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // sampled mid-cycle, away from the driving edge
    always @(negedge clk)
    begin
        if (!rst)
        begin
            cycle_cnt = cycle_cnt + 1;
            if (mem_req.rd && mem_req.wr)
            begin
                $display("memory request has rd and wr high at once at %0t", $time);
                bus_err_cnt = bus_err_cnt + 1;
            end
            if (mem_rsp.done && mem_req.rd)
            begin
                rd_cnt    = rd_cnt + 1;
                fill_addr = mem_req.addr;
                fill_line = mem_rsp.rdata;
            end
            if (mem_rsp.done && mem_req.wr)
            begin
                wr_cnt = wr_cnt + 1;
            end
        end
    end

    initial
    begin
        wait (cycle_cnt >= MAX_CYCLES);
        $display("timeout after %0d cycles, a request never finished", cycle_cnt);
        $display("=== FAIL ===");
        $finish;
    end

    function automatic int total_errors();
        return err_cnt + bus_err_cnt;
    endfunction

    function automatic logic [31:0] line_addr(tag_t tag, logic [`SET_ADDR_LEN-1:0] set_idx,
        logic [`LINE_ADDR_LEN-1:0] word, logic [1:0] offset);
        cache_addr_t a;
        a         = '0;
        a.tag     = tag;
        a.set_idx = set_idx;
        a.word    = word;
        a.offset  = offset;
        return a;
    endfunction

    // byte 0 is the top byte of the word
    function automatic logic [31:0] merge_expect(logic [31:0] old, store_kind_e kind,
        logic [1:0] off, logic [31:0] d);
        logic [31:0] r;
        r = old;
        if (kind == ST_WORD)
        begin
            r = d;
        end
        else if (kind == ST_HALF)
        begin
            if (off == 2'd0)
            begin
                r[31:16] = d[15:0];
            end
            else
            begin
                r[15:0] = d[15:0];
            end
        end
        else
        begin
            case (off)
                2'd0: r[31:24] = d[7:0];
                2'd1: r[23:16] = d[7:0];
                2'd2: r[15:8]  = d[7:0];
                default: r[7:0] = d[7:0];
            endcase
        end
        return r;
    endfunction

    task automatic check_word(string name, logic [`WORD_W-1:0] got, logic [`WORD_W-1:0] exp);
        if (got !== exp)
        begin
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
            err_cnt = err_cnt + 1;
        end
    endtask

    task automatic check_line(string name, line_t got, line_t exp);
        if (got !== exp)
        begin
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
            err_cnt = err_cnt + 1;
        end
    endtask

    task automatic check_addr(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp)
        begin
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
            err_cnt = err_cnt + 1;
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp)
        begin
            $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
            err_cnt = err_cnt + 1;
        end
    endtask

    task automatic report_test(string name, int errs_before);
        test_cnt = test_cnt + 1;
        if (total_errors() == errs_before)
        begin
            $display("test %s ok", name);
        end
        else
        begin
            test_fail_cnt = test_fail_cnt + 1;
            $display("test %s failed", name);
        end
    endtask

    // one request, held until finish, dropped on the next edge
    task automatic access(logic rd, logic wr, store_kind_e kind, logic [31:0] addr,
        logic [`WORD_W-1:0] wdata, output logic [`WORD_W-1:0] rdata);
        @(posedge clk);
        cpu_req <= '{rd: rd, wr: wr, kind: kind, addr: addr, wdata: wdata};
        @(negedge clk);
        while (!cpu_rsp.finish)
        begin
            // request present and not finished
            check_flag("cpu_rsp.miss", cpu_rsp.miss, 1'b1);
            @(negedge clk);
        end
        check_flag("cpu_rsp.miss", cpu_rsp.miss, 1'b0);
        rdata = cpu_rsp.rdata;
        @(posedge clk);
        cpu_req <= '0;
    endtask

    task automatic store(store_kind_e kind, logic [31:0] addr, logic [`WORD_W-1:0] wdata);
        logic [`WORD_W-1:0] ignored;
        access(1'b0, 1'b1, kind, addr, wdata, ignored);
    endtask

    // a miss must refill the aligned line and return its word
    task automatic read_check(logic [31:0] addr, logic exp_miss,
        output logic [`WORD_W-1:0] data);
        int          rd_before;
        cache_addr_t a;
        cache_addr_t aligned;
        rd_before = rd_cnt;
        a         = addr;
        aligned   = addr;
        aligned.word   = '0;
        aligned.offset = '0;
        access(1'b1, 1'b0, ST_WORD, addr, '0, data);
        check_flag("refill issued", rd_cnt != rd_before, exp_miss);
        if (exp_miss)
        begin
            check_addr("mem_req.addr", fill_addr, aligned);
            check_word("cpu_rsp.rdata", data, fill_line[a.word]);
        end
    endtask

    task automatic test_reset_first_read();
        int                 errs;
        int                 wr_before;
        logic [`WORD_W-1:0] data;
        errs      = total_errors();
        wr_before = wr_cnt;
        @(negedge clk);
        check_flag("cpu_rsp.finish", cpu_rsp.finish, 1'b0);
        check_flag("mem_req.rd", mem_req.rd, 1'b0);
        check_flag("mem_req.wr", mem_req.wr, 1'b0);
        check_word("cpu_rsp.rdata", cpu_rsp.rdata, '0);
        read_check(line_addr(10'd1, TEST_SET, STORE_WORD, 2'd0), 1'b1, data);
        check_flag("write-back on cold miss", wr_cnt != wr_before, 1'b0);
        first_line = fill_line;
        first_val  = data;
        report_test("reset and first read", errs);
    endtask

    task automatic test_same_line_hit();
        int                 errs;
        logic [`WORD_W-1:0] data;
        errs = total_errors();
        read_check(line_addr(10'd1, TEST_SET, 3'd5, 2'd0), 1'b0, data);
        check_word("hit word 5", data, first_line[5]);
        read_check(line_addr(10'd1, TEST_SET, STORE_WORD, 2'd0), 1'b0, data);
        check_word("hit word 3", data, first_val);
        report_test("same line hit", errs);
    endtask

    task automatic test_store_merge();
        int                 errs;
        int                 rd_before;
        logic [`WORD_W-1:0] exp;
        logic [`WORD_W-1:0] got;
        store_kind_e        kinds [7] = '{ST_BYTE, ST_BYTE, ST_BYTE, ST_BYTE,
                                          ST_HALF, ST_HALF, ST_WORD};
        logic [1:0]         offs  [7] = '{2'd0, 2'd1, 2'd2, 2'd3, 2'd0, 2'd2, 2'd0};
        logic [31:0]        datas [7] = '{32'h5a5a_5aa1, 32'hffff_ffb2, 32'h0000_00c3,
                                          32'h1234_56d4, 32'hdead_1357, 32'h0000_9bdf,
                                          32'hcafe_f00d};
        errs      = total_errors();
        rd_before = rd_cnt;
        exp       = first_val;
        for (int i = 0; i < 7; i++)
        begin
            exp = merge_expect(exp, kinds[i], offs[i], datas[i]);
            store(kinds[i], line_addr(10'd1, TEST_SET, STORE_WORD, offs[i]), datas[i]);
            read_check(line_addr(10'd1, TEST_SET, STORE_WORD, 2'd0), 1'b0, got);
            check_word("merged word", got, exp);
        end
        check_flag("refill during stores", rd_cnt != rd_before, 1'b0);
        stored_word            = exp;
        first_line[STORE_WORD] = exp;
        report_test("store merge", errs);
    endtask

    task automatic test_dirty_writeback();
        int                 errs;
        int                 wb_before;
        int                 wr_before;
        logic [`WORD_W-1:0] data;
        errs      = total_errors();
        wb_before = wb_cnt;
        wr_before = wr_cnt;
        // remaining ways take tags 2 .. WAY_CNT
        for (int t = 2; t <= `WAY_CNT; t++)
        begin
            read_check(line_addr(tag_t'(t), TEST_SET, 3'd0, 2'd0), 1'b1, data);
        end
        check_flag("write-back before set full", wr_cnt != wr_before, 1'b0);
        // counter wrapped, the dirty tag 1 line goes
        read_check(line_addr(tag_t'(`WAY_CNT + 1), TEST_SET, 3'd0, 2'd0), 1'b1, data);
        check_flag("write-back issued", wb_cnt == wb_before + 1, 1'b1);
        check_addr("write-back addr", wb_addr, line_addr(10'd1, TEST_SET, 3'd0, 2'd0));
        check_line("write-back line", wb_line, first_line);
        check_word("written back store", wb_line[STORE_WORD], stored_word);
        check_addr("refill addr", fill_addr,
            line_addr(tag_t'(`WAY_CNT + 1), TEST_SET, 3'd0, 2'd0));
        report_test("dirty write-back", errs);
    endtask

    task automatic test_fifo_order();
        int                 errs;
        logic [`WORD_W-1:0] data;
        errs = total_errors();
        // should replace ways 1 .. WAY_CNT-1 in turn
        for (int t = `WAY_CNT + 2; t <= 2 * `WAY_CNT; t++)
        begin
            read_check(line_addr(tag_t'(t), TEST_SET, 3'd1, 2'd0), 1'b1, data);
        end
        // way 0 kept its line, so all newer tags still hit
        for (int t = `WAY_CNT + 1; t <= 2 * `WAY_CNT; t++)
        begin
            read_check(line_addr(tag_t'(t), TEST_SET, 3'd2, 2'd0), 1'b0, data);
        end
        // evicted tags miss again
        for (int t = 2; t <= `WAY_CNT; t++)
        begin
            read_check(line_addr(tag_t'(t), TEST_SET, 3'd4, 2'd0), 1'b1, data);
        end
        report_test("fifo order", errs);
    endtask

    task automatic test_clean_eviction();
        int                 errs;
        int                 wb_before;
        int                 wr_before;
        logic [`WORD_W-1:0] data;
        errs      = total_errors();
        wb_before = wb_cnt;
        wr_before = wr_cnt;
        // victim is the clean tag 2*WAY_CNT line
        read_check(line_addr(10'd1, TEST_SET, STORE_WORD, 2'd0), 1'b1, data);
        check_word("reloaded store", data, stored_word);
        read_check(line_addr(tag_t'(`WAY_CNT + 1), TEST_SET, 3'd0, 2'd0), 1'b1, data);
        check_flag("wr on clean victim", wr_cnt != wr_before, 1'b0);
        check_flag("write-back log changed", wb_cnt != wb_before, 1'b0);
        report_test("clean eviction", errs);
    endtask

    initial
    begin
        rst     = 1'b1;
        cpu_req = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        test_reset_first_read();
        test_same_line_hit();
        test_store_merge();
        test_dirty_writeback();
        test_fifo_order();
        test_clean_eviction();
        $display("tests %0d, failed %0d, errors %0d", test_cnt, test_fail_cnt, total_errors());
        if (total_errors() == 0)
        begin
            $display("=== PASS ===");
        end
        else
        begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+.
cache_pkg.sv
mem_bus_pkg.sv
cache_ctrl_fsm.sv
replace_ctr.sv
tag_store.sv
data_store.sv
data_cache.sv
tb_mem_model.sv
tb_data_cache.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the data cache testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_data_cache -f verilog.f \
    > build.log 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
    cat build.log
    echo "verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/Vtb_data_cache > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "=== FAIL ===" sim.log; then
    exit 1
fi
if ! grep -q "=== PASS ===" sim.log; then
    echo "simulation log has no verdict"
    exit 1
fi
exit 0
